//--- soc_top.f
common/soc_map_pkg.sv
common/soc_bus_pkg.sv
hw/boot_rom.sv
hw/sys_ram.sv
hw/bridge/timer.sv
hw/bridge/system_registers.sv
hw/bridge/peripheral_bridge.sv
hw/bus/bus_access.sv
hw/soc_top.sv
verification/soc_properties.sv
verification/soc_tb.sv

//--- Makefile
# Verilator build and run of the SoC bus testbench

.PHONY: help test clean

help:
	@echo "make test   build and run soc_tb with Verilator"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -Mdir obj_dir -f soc_top.f
	@out=$$(./obj_dir/Vsoc_tb); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- verification/soc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module soc_tb
	import soc_bus_pkg::*, soc_map_pkg::*;
();

	localparam int unsigned TIMEOUT_CYCLES = 100;

	logic        clock = 1'b0;
	logic        rst_n;
	logic        ibus_request;
	addr_t       ibus_address;
	bus_req_t    dbus_req;
	bus_rsp_t    ibus_rsp;
	bus_rsp_t    dbus_rsp;
	led_t        led_n;
	logic        timer_irq;

	integer      seed;
	int unsigned cycle_count = 0;
	int unsigned ibus_ready_cycle;
	int unsigned dbus_ready_cycle;
	int unsigned error_count = 0;
	int unsigned last_error_count = 0;
	int unsigned check_count = 0;
	int unsigned tests_run = 0;
	int unsigned tests_failed = 0;

	// Shadow state of what the testbench wrote
	word_t       ram_shadow [RAM_WORDS];
	led_t        led_shadow = '0;

	// Reads waiting for the comparing process
	string       what_q [$];
	word_t       got_q [$];
	word_t       exp_q [$];

	soc_top dut0 (
		.i_clock        (clock),
		.i_rst_n        (rst_n),
		.i_ibus_request (ibus_request),
		.i_ibus_address (ibus_address),
		.o_ibus_rsp     (ibus_rsp),
		.i_dbus_req     (dbus_req),
		.o_dbus_rsp     (dbus_rsp),
		.o_led_n        (led_n),
		.o_timer_irq    (timer_irq)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// ====================================================================
	// Reference model and address helpers
	// ====================================================================

	// Timer reads are checked where they happen
	function automatic word_t expected_read(input addr_t address);
		int unsigned word_index;
		word_t       result;
		word_index = address >> 2;
		result = '0;
		case (address[31:28])
			REGION_ROM: result = {ROM_TAG, 16'(word_index % ROM_WORDS)};
			REGION_RAM: result = ram_shadow[word_index % RAM_WORDS];
			REGION_BRIDGE: begin
				if (address[27:24] == FAR_SYSREG) begin
					case (address[4:2])
						3'd0:    result = DEVICE_ID;
						3'd1:    result = RAM_SIZE_BYTES;
						3'd2:    result = word_t'(led_shadow);
						default: result = '0;
					endcase
				end
			end
			default: result = '0;
		endcase
		return result;
	endfunction

	function automatic addr_t region_address(input region_t region, input int unsigned index);
		return (addr_t'(region) << 28) | addr_t'(index << 2);
	endfunction

	function automatic addr_t periph_address(input far_sel_t far, input int unsigned reg_index);
		return {REGION_BRIDGE, far, 24'(reg_index << 2)};
	endfunction

	always @(negedge clock) begin : compare_reads
		string what;
		word_t got;
		word_t exp;
		while (got_q.size() > 0) begin
			what = what_q.pop_front();
			got  = got_q.pop_front();
			exp  = exp_q.pop_front();
			check_count++;
			if (got !== exp) begin
				$display("error %s got %h expected %h", what, got, exp);
				error_count++;
			end
		end
	end

	task automatic expect_word(input string signal_name, input addr_t address, input word_t got);
		what_q.push_back($sformatf("%s at %h", signal_name, address));
		got_q.push_back(got);
		exp_q.push_back(expected_read(address));
	endtask

	// ====================================================================
	// Port access tasks
	// ====================================================================

	task automatic wait_ready(input logic data_port, output logic seen);
		int unsigned waited;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < TIMEOUT_CYCLES) begin
			@(posedge clock);
			#1;
			waited++;
			seen = data_port ? dbus_rsp.ready : ibus_rsp.ready;
		end
	endtask

	task automatic wait_irq(input logic level, input int unsigned limit, output logic seen);
		int unsigned waited;
		waited = 0;
		seen = (timer_irq == level);
		while (!seen && waited < limit) begin
			@(posedge clock);
			#1;
			waited++;
			seen = (timer_irq == level);
		end
	endtask

	task automatic ibus_read(input addr_t address, output word_t data);
		logic seen;
		ibus_request = 1'b1;
		ibus_address = address;
		wait_ready(1'b0, seen);
		ibus_request = 1'b0;
		data = ibus_rsp.rdata;
		ibus_ready_cycle = cycle_count;
		if (!seen) begin
			$display("instruction port read at %h never got a ready", address);
			error_count++;
		end
	endtask

	task automatic dbus_access(input logic rw, input addr_t address, input word_t wdata,
			output word_t data);
		logic seen;
		dbus_req = '{request: 1'b1, rw: rw, address: address, wdata: wdata};
		wait_ready(1'b1, seen);
		dbus_req.request = 1'b0;
		data = dbus_rsp.rdata;
		dbus_ready_cycle = cycle_count;
		if (!seen) begin
			$display("data port access at %h never got a ready", address);
			error_count++;
		end
		if (rw && address[31:28] == REGION_RAM) begin
			ram_shadow[(address >> 2) % RAM_WORDS] = wdata;
		end
		if (rw && address[31:24] == {REGION_BRIDGE, FAR_SYSREG} && address[4:2] == 3'd2) begin
			led_shadow = wdata[7:0];
		end
	endtask

	// One cycle lets the comparing process drain first
	task automatic finish_test(input string name);
		@(posedge clock);
		#1;
		tests_run++;
		if (error_count == last_error_count) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, error_count - last_error_count);
			tests_failed++;
		end
		last_error_count = error_count;
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================

	initial begin : stimulus
		word_t       data;
		word_t       ibus_data;
		word_t       first;
		word_t       second;
		logic        seen;
		led_t        leds;
		int unsigned index;
		int unsigned pick;
		int unsigned swap;
		int unsigned written [$];
		int unsigned order [$];

		seed = 32306;
		rst_n = 1'b0;
		ibus_request = 1'b0;
		ibus_address = '0;
		dbus_req = '0;
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;
		@(posedge clock);
		#1;

		for (int i = 0; i < 12; i++) begin
			index = $unsigned($random(seed)) % ROM_WORDS;
			ibus_read(region_address(REGION_ROM, index), data);
			expect_word("o_ibus_rsp.rdata", region_address(REGION_ROM, index), data);
		end
		finish_test("rom reads");

		for (int i = 0; i < 16; i++) begin
			index = $unsigned($random(seed)) % RAM_WORDS;
			written.push_back(index);
			dbus_access(1'b1, region_address(REGION_RAM, index), word_t'($random(seed)), data);
		end
		// Fisher-Yates shuffle of the read order
		order = written;
		for (int i = order.size() - 1; i > 0; i--) begin
			pick = $unsigned($random(seed)) % (i + 1);
			swap = order[i];
			order[i] = order[pick];
			order[pick] = swap;
		end
		foreach (order[i]) begin
			dbus_access(1'b0, region_address(REGION_RAM, order[i]), '0, data);
			expect_word("o_dbus_rsp.rdata", region_address(REGION_RAM, order[i]), data);
		end
		for (int i = 0; i < 4; i++) begin
			ibus_read(region_address(REGION_RAM, written[i]), data);
			expect_word("o_ibus_rsp.rdata", region_address(REGION_RAM, written[i]), data);
		end
		finish_test("ram write and shuffled read");

		fork
			dbus_access(1'b0, region_address(REGION_RAM, written[0]), '0, data);
			ibus_read(region_address(REGION_ROM, 77), ibus_data);
		join
		expect_word("o_dbus_rsp.rdata", region_address(REGION_RAM, written[0]), data);
		expect_word("o_ibus_rsp.rdata", region_address(REGION_ROM, 77), ibus_data);
		if (dbus_ready_cycle >= ibus_ready_cycle) begin
			$display("data port was not served first when both ports requested together");
			error_count++;
		end
		finish_test("simultaneous requests");

		ibus_read(periph_address(FAR_SYSREG, 0), data);
		expect_word("o_ibus_rsp.rdata", periph_address(FAR_SYSREG, 0), data);
		dbus_access(1'b0, periph_address(FAR_SYSREG, 1), '0, data);
		expect_word("o_dbus_rsp.rdata", periph_address(FAR_SYSREG, 1), data);
		leds = led_t'($random(seed));
		dbus_access(1'b1, periph_address(FAR_SYSREG, 2), word_t'(leds), data);
		dbus_access(1'b0, periph_address(FAR_SYSREG, 2), '0, data);
		expect_word("o_dbus_rsp.rdata", periph_address(FAR_SYSREG, 2), data);
		if (led_n !== ~leds) begin
			$display("error o_led_n got %h expected %h", led_n, ~leds);
			error_count++;
		end
		finish_test("system registers");

		dbus_access(1'b0, periph_address(FAR_TIMER, 0), '0, first);
		dbus_access(1'b0, periph_address(FAR_TIMER, 0), '0, second);
		if (second <= first) begin
			$display("error o_dbus_rsp.rdata timer count %h then %h", first, second);
			error_count++;
		end
		dbus_access(1'b1, periph_address(FAR_TIMER, 1), second + 32'd200, data);
		if (timer_irq !== 1'b0) begin
			$display("error o_timer_irq got %h expected %h", timer_irq, 1'b0);
			error_count++;
		end
		wait_irq(1'b1, 1000, seen);
		if (!seen) begin
			$display("timer interrupt did not rise after the compare value was reached");
			error_count++;
		end
		dbus_access(1'b1, periph_address(FAR_TIMER, 1), '0, data);
		wait_irq(1'b0, 20, seen);
		if (!seen) begin
			$display("timer interrupt stayed high after compare was cleared");
			error_count++;
		end
		finish_test("timer");

		ibus_read(32'h3000_0040, data);
		expect_word("o_ibus_rsp.rdata", 32'h3000_0040, data);
		dbus_access(1'b0, 32'hF000_0100, '0, data);
		expect_word("o_dbus_rsp.rdata", 32'hF000_0100, data);
		dbus_access(1'b0, periph_address(far_sel_t'(4'h3), 0), '0, data);
		expect_word("o_dbus_rsp.rdata", periph_address(far_sel_t'(4'h3), 0), data);
		finish_test("unmapped reads");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/soc_properties.sv
`timescale 1ns/100ps
`default_nettype none

module soc_properties
	import soc_bus_pkg::*;
(
	input wire           i_clock,
	input wire           i_rst_n,
	input wire bus_rsp_t i_ibus_rsp,
	input wire bus_rsp_t i_dbus_rsp,
	input wire led_t     i_led_n
);

	// Readies are single cycle pulses
	ibus_ready_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_ibus_rsp.ready |=> !i_ibus_rsp.ready)
		else $error("instruction port ready held longer than one cycle");

	dbus_ready_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dbus_rsp.ready |=> !i_dbus_rsp.ready)
		else $error("data port ready held longer than one cycle");

	// One access in flight
	ready_exclusive: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(i_ibus_rsp.ready && i_dbus_rsp.ready))
		else $error("both port readies high together");

	ready_low_after_reset: assert property (@(posedge i_clock)
		!i_rst_n |=> !i_ibus_rsp.ready && !i_dbus_rsp.ready)
		else $error("port ready high right after reset");

	// LEDs dark during reset
	leds_off_in_reset: assert property (@(posedge i_clock)
		!i_rst_n |=> i_led_n == '1)
		else $error("LED outputs not all ones in reset");

endmodule

bind soc_top soc_properties props0 (
	.i_clock    (i_clock),
	.i_rst_n    (i_rst_n),
	.i_ibus_rsp (o_ibus_rsp),
	.i_dbus_rsp (o_dbus_rsp),
	.i_led_n    (o_led_n)
);

`default_nettype wire

//--- hw/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top
	import soc_bus_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_rst_n,

	// Instruction port
	input  wire           i_ibus_request,
	input  wire addr_t    i_ibus_address,
	output bus_rsp_t      o_ibus_rsp,

	// Data port
	input  wire bus_req_t i_dbus_req,
	output bus_rsp_t      o_dbus_rsp,

	output led_t          o_led_n,
	output logic          o_timer_irq
);

	// Shared target bus
	bus_req_t tgt_req;
	logic     rom_strobe;
	logic     ram_strobe;
	logic     bridge_strobe;
	bus_rsp_t rom_rsp;
	bus_rsp_t ram_rsp;
	bus_rsp_t bridge_rsp;

	bus_access bus0 (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_ibus_request  (i_ibus_request),
		.i_ibus_address  (i_ibus_address),
		.o_ibus_rsp      (o_ibus_rsp),
		.i_dbus_req      (i_dbus_req),
		.o_dbus_rsp      (o_dbus_rsp),
		.o_tgt_req       (tgt_req),
		.o_rom_strobe    (rom_strobe),
		.o_ram_strobe    (ram_strobe),
		.o_bridge_strobe (bridge_strobe),
		.i_rom_rsp       (rom_rsp),
		.i_ram_rsp       (ram_rsp),
		.i_bridge_rsp    (bridge_rsp)
	);

	// ROM at 0x0000_0000
	boot_rom rom0 (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_strobe (rom_strobe),
		.i_req    (tgt_req),
		.o_rsp    (rom_rsp)
	);

	// RAM at 0x2000_0000 in place of the SDRAM
	sys_ram ram0 (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_strobe (ram_strobe),
		.i_req    (tgt_req),
		.o_rsp    (ram_rsp)
	);

	// Peripherals at 0x5000_0000
	peripheral_bridge bridge0 (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_strobe    (bridge_strobe),
		.i_req       (tgt_req),
		.o_rsp       (bridge_rsp),
		.o_led_n     (o_led_n),
		.o_timer_irq (o_timer_irq)
	);

endmodule

`default_nettype wire

//--- hw/bus/bus_access.sv
`timescale 1ns/100ps
`default_nettype none

module bus_access
	import soc_bus_pkg::*, soc_map_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_rst_n,

	// Instruction port, read only
	input  wire           i_ibus_request,
	input  wire addr_t    i_ibus_address,
	output bus_rsp_t      o_ibus_rsp,

	// Data port
	input  wire bus_req_t i_dbus_req,
	output bus_rsp_t      o_dbus_rsp,

	// Target side
	output bus_req_t      o_tgt_req,
	output logic          o_rom_strobe,
	output logic          o_ram_strobe,
	output logic          o_bridge_strobe,
	input  wire bus_rsp_t i_rom_rsp,
	input  wire bus_rsp_t i_ram_rsp,
	input  wire bus_rsp_t i_bridge_rsp
);

	arb_state_t state;
	logic       owner_data;
	logic       none_strobe;
	logic       none_ready;

	logic       rw_q;
	addr_t      address_q;
	word_t      wdata_q;
	word_t      ibus_rdata_q;
	word_t      dbus_rdata_q;

	bus_req_t   sel_req;
	region_t    sel_region;
	region_t    cur_region;
	logic       any_request;
	logic       hit_rom;
	logic       hit_ram;
	logic       hit_bridge;
	logic       tgt_ready;
	word_t      tgt_rdata;

	// Data port wins a tie
	always_comb begin
		if (i_dbus_req.request) begin
			sel_req = i_dbus_req;
		end else begin
			sel_req = '{
				request: i_ibus_request,
				rw:      1'b0,
				address: i_ibus_address,
				wdata:   '0
			};
		end
	end

	assign any_request = i_dbus_req.request | i_ibus_request;
	assign sel_region  = sel_req.address[31:28];
	assign cur_region  = address_q[31:28];
	assign hit_rom     = (sel_region == REGION_ROM);
	assign hit_ram     = (sel_region == REGION_RAM);
	assign hit_bridge  = (sel_region == REGION_BRIDGE);

	// Only one access is in flight so the readies can be merged
	assign tgt_ready = i_rom_rsp.ready | i_ram_rsp.ready | i_bridge_rsp.ready | none_ready;

	always_comb begin
		case (cur_region)
			REGION_ROM:    tgt_rdata = i_rom_rsp.rdata;
			REGION_RAM:    tgt_rdata = i_ram_rsp.rdata;
			REGION_BRIDGE: tgt_rdata = i_bridge_rsp.rdata;
			default:       tgt_rdata = '0;
		endcase
	end

	// ====================================================================
	// Arbiter FSM
	// ====================================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state           <= ARB_IDLE;
			owner_data      <= 1'b0;
			o_rom_strobe    <= 1'b0;
			o_ram_strobe    <= 1'b0;
			o_bridge_strobe <= 1'b0;
			none_strobe     <= 1'b0;
			none_ready      <= 1'b0;
		end else begin
			o_rom_strobe    <= 1'b0;
			o_ram_strobe    <= 1'b0;
			o_bridge_strobe <= 1'b0;
			none_strobe     <= 1'b0;
			// Unmapped region answers like a one cycle target
			none_ready      <= none_strobe;
			case (state)
				ARB_IDLE: begin
					if (any_request) begin
						owner_data      <= i_dbus_req.request;
						o_rom_strobe    <= hit_rom;
						o_ram_strobe    <= hit_ram;
						o_bridge_strobe <= hit_bridge;
						none_strobe     <= !(hit_rom || hit_ram || hit_bridge);
						state           <= ARB_WAIT;
					end
				end
				ARB_WAIT: begin
					if (tgt_ready) begin
						state <= ARB_DONE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// Latched access and per port read data
	always_ff @(posedge i_clock) begin
		if (state == ARB_IDLE && any_request) begin
			rw_q      <= sel_req.rw;
			address_q <= sel_req.address;
			wdata_q   <= sel_req.wdata;
		end
		if (state == ARB_WAIT && tgt_ready) begin
			if (owner_data) begin
				dbus_rdata_q <= tgt_rdata;
			end else begin
				ibus_rdata_q <= tgt_rdata;
			end
		end
	end

	assign o_tgt_req = '{request: 1'b0, rw: rw_q, address: address_q, wdata: wdata_q};

	assign o_ibus_rsp = '{ready: (state == ARB_DONE) && !owner_data, rdata: ibus_rdata_q};
	assign o_dbus_rsp = '{ready: (state == ARB_DONE) && owner_data, rdata: dbus_rdata_q};

endmodule

`default_nettype wire

//--- hw/bridge/peripheral_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module peripheral_bridge
	import soc_bus_pkg::*, soc_map_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_rst_n,

	// Near side
	input  wire           i_strobe,
	input  wire bus_req_t i_req,
	output bus_rsp_t      o_rsp,

	output led_t          o_led_n,
	output logic          o_timer_irq
);

	bus_req_t far_req;
	logic     timer_strobe;
	logic     sysreg_strobe;
	logic     unknown_strobe;
	logic     unknown_ready;
	bus_rsp_t timer_rsp;
	bus_rsp_t sysreg_rsp;

	far_sel_t near_sel;
	far_sel_t far_sel;
	logic     far_ready;
	word_t    far_rdata;
	logic     near_ready;
	word_t    near_rdata;

	assign near_sel = i_req.address[27:24];
	assign far_sel  = far_req.address[27:24];

	// ====================================================================
	// Near to far registers
	// ====================================================================

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			timer_strobe   <= 1'b0;
			sysreg_strobe  <= 1'b0;
			unknown_strobe <= 1'b0;
			unknown_ready  <= 1'b0;
			near_ready     <= 1'b0;
		end else begin
			timer_strobe   <= i_strobe && (near_sel == FAR_TIMER);
			sysreg_strobe  <= i_strobe && (near_sel == FAR_SYSREG);
			unknown_strobe <= i_strobe && (near_sel != FAR_TIMER) && (near_sel != FAR_SYSREG);
			// Unknown far code answers zero on the same beat as a peripheral
			unknown_ready  <= unknown_strobe;
			near_ready     <= far_ready;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_strobe) begin
			far_req <= i_req;
		end
		if (far_ready) begin
			near_rdata <= far_rdata;
		end
	end

	// Far read mux
	assign far_ready = timer_rsp.ready | sysreg_rsp.ready | unknown_ready;

	always_comb begin
		case (far_sel)
			FAR_TIMER:  far_rdata = timer_rsp.rdata;
			FAR_SYSREG: far_rdata = sysreg_rsp.rdata;
			default:    far_rdata = '0;
		endcase
	end

	assign o_rsp = '{ready: near_ready, rdata: near_rdata};

	timer timer0 (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_strobe (timer_strobe),
		.i_req    (far_req),
		.o_rsp    (timer_rsp),
		.o_irq    (o_timer_irq)
	);

	system_registers sysreg0 (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_strobe (sysreg_strobe),
		.i_req    (far_req),
		.o_rsp    (sysreg_rsp),
		.o_led_n  (o_led_n)
	);

endmodule

`default_nettype wire

//--- hw/bridge/system_registers.sv
`timescale 1ns/100ps
`default_nettype none

module system_registers
	import soc_bus_pkg::*, soc_map_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_rst_n,
	input  wire           i_strobe,
	input  wire bus_req_t i_req,
	output bus_rsp_t      o_rsp,
	output led_t          o_led_n
);

	reg_index_t index;
	led_t       led_q;
	logic       ready_q;
	word_t      rdata_q;

	assign index = i_req.address[4:2];

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			led_q   <= '0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= i_strobe;
			if (i_strobe && i_req.rw && index == SYSREG_LEDS) begin
				led_q <= i_req.wdata[$bits(led_t)-1:0];
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_strobe) begin
			case (index)
				SYSREG_DEVICE_ID: rdata_q <= DEVICE_ID;
				SYSREG_RAM_SIZE:  rdata_q <= RAM_SIZE_BYTES;
				SYSREG_LEDS:      rdata_q <= word_t'(led_q);
				default:          rdata_q <= '0;
			endcase
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

	// LEDs on the board are active low
	assign o_led_n = ~led_q;

endmodule

`default_nettype wire

//--- hw/bridge/timer.sv
`timescale 1ns/100ps
`default_nettype none

module timer
	import soc_bus_pkg::*, soc_map_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_rst_n,
	input  wire           i_strobe,
	input  wire bus_req_t i_req,
	output bus_rsp_t      o_rsp,
	output logic          o_irq
);

	reg_index_t index;
	word_t      count_q;
	word_t      compare_q;
	logic       ready_q;
	word_t      rdata_q;

	assign index = i_req.address[4:2];

	// Counter runs every cycle and wraps
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			count_q   <= '0;
			compare_q <= '0;
			ready_q   <= 1'b0;
			o_irq     <= 1'b0;
		end else begin
			count_q <= count_q + 1'b1;
			ready_q <= i_strobe;
			if (i_strobe && i_req.rw && index == TIMER_REG_COMPARE) begin
				compare_q <= i_req.wdata;
			end
			// Compare of zero keeps the interrupt off
			o_irq <= (compare_q != '0) && (count_q >= compare_q);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_strobe) begin
			case (index)
				TIMER_REG_COUNT:   rdata_q <= count_q;
				TIMER_REG_COMPARE: rdata_q <= compare_q;
				default:           rdata_q <= '0;
			endcase
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- hw/sys_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sys_ram
	import soc_bus_pkg::*, soc_map_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_rst_n,
	input  wire           i_strobe,
	input  wire bus_req_t i_req,
	output bus_rsp_t      o_rsp
);

	word_t                     mem [RAM_WORDS];
	logic [RAM_INDEX_BITS-1:0] index;
	logic                      ready_q;
	word_t                     rdata_q;

	assign index = i_req.address[2 +: RAM_INDEX_BITS];

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= i_strobe;
		end
	end

	// Read returns the old word on a write
	always_ff @(posedge i_clock) begin
		if (i_strobe) begin
			rdata_q <= mem[index];
			if (i_req.rw) begin
				mem[index] <= i_req.wdata;
			end
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- hw/boot_rom.sv
`timescale 1ns/100ps
`default_nettype none

module boot_rom
	import soc_bus_pkg::*, soc_map_pkg::*;
(
	input  wire           i_clock,
	input  wire           i_rst_n,
	input  wire           i_strobe,
	input  wire bus_req_t i_req,
	output bus_rsp_t      o_rsp
);

	logic [ROM_INDEX_BITS-1:0] index;
	logic                      ready_q;
	word_t                     rdata_q;

	// Boot image word for a given index
	function automatic word_t rom_word(input logic [ROM_INDEX_BITS-1:0] i);
		return {ROM_TAG, 16'(i)};
	endfunction

	assign index = i_req.address[2 +: ROM_INDEX_BITS];

	// Writes land here too and just get their ready
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= i_strobe;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_strobe) begin
			rdata_q <= rom_word(index);
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- common/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	// ====================================================================
	// Bus words
	// ====================================================================

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// LED register of the system registers
	typedef logic [7:0] led_t;

	// Request side of a port or target
	// rw is 1 for a write
	typedef struct packed {
		logic  request;
		logic  rw;
		addr_t address;
		word_t wdata;
	} bus_req_t;

	// Response side, ready is a one cycle pulse
	typedef struct packed {
		logic  ready;
		word_t rdata;
	} bus_rsp_t;

	// ====================================================================
	// Arbiter states
	// ====================================================================

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WAIT,
		ARB_DONE
	} arb_state_t;

endpackage

`default_nettype wire

//--- common/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// ====================================================================
	// Region decode on address bits 31:28
	// ====================================================================

	typedef logic [3:0] region_t;

	localparam region_t REGION_ROM    = 4'h0;
	localparam region_t REGION_RAM    = 4'h2;
	localparam region_t REGION_BRIDGE = 4'h5;

	// Far decode behind the bridge on bits 27:24
	typedef logic [3:0] far_sel_t;

	localparam far_sel_t FAR_TIMER  = 4'h5;
	localparam far_sel_t FAR_SYSREG = 4'h9;

	// Peripheral register index from bits 4:2
	typedef logic [2:0] reg_index_t;

	localparam reg_index_t TIMER_REG_COUNT   = 3'd0;
	localparam reg_index_t TIMER_REG_COMPARE = 3'd1;
	localparam reg_index_t SYSREG_DEVICE_ID  = 3'd0;
	localparam reg_index_t SYSREG_RAM_SIZE   = 3'd1;
	localparam reg_index_t SYSREG_LEDS       = 3'd2;

	// ====================================================================
	// Memories
	// ====================================================================

	localparam int unsigned ROM_WORDS      = 256;
	localparam int unsigned ROM_INDEX_BITS = $clog2(ROM_WORDS);
	localparam int unsigned RAM_WORDS      = 1024;
	localparam int unsigned RAM_INDEX_BITS = $clog2(RAM_WORDS);

	// Boot image word i is {ROM_TAG, i}
	localparam logic [15:0] ROM_TAG = 16'hB007;

	localparam logic [31:0] DEVICE_ID      = 32'd6;
	localparam logic [31:0] RAM_SIZE_BYTES = 32'(RAM_WORDS * 4);

endpackage

`default_nettype wire
